// ==== bench/mat_stim.txt ====
# kind (W write, R read, P poll status until done), address, write data, expected data, expected resp
# all hex; resp 0 is OKAY, 2 is SLVERR
R 004 00000000 00000000 0
R 008 00000000 00000003 0
R 014 00000000 00000000 0
# slots 0 and 1 shaped 2x3, a few elements, negatives too
W 010 00000032 00000000 0
W 014 00000032 00000000 0
R 010 00000000 00000032 0
W 100 00000064 00000000 0
W 108 000000ec 00000000 0
W 118 000000fd 00000000 0
W 180 00000064 00000000 0
W 198 00000005 00000000 0
R 118 00000000 fffffffd 0
R 108 00000000 ffffffec 0
# scale on empty slot 2 into slot 3 fails
W 000 000000a3 00000000 0
P 004 00000000 00000006 0
R 01c 00000000 00000000 0
# add 0 + 1 into 2, 100 + 100 wraps
W 000 00000006 00000000 0
P 004 00000000 00000002 0
R 200 00000000 ffffffc8 0
R 218 00000000 00000002 0
R 018 00000000 00000032 0
# sub 0 - 1 into 3
W 000 00000047 00000000 0
P 004 00000000 00000002 0
R 298 00000000 fffffff8 0
# scalar -5, then scale 0 into 2
W 008 000000fb 00000000 0
R 008 00000000 fffffffb 0
W 000 00000082 00000000 0
P 004 00000000 00000002 0
R 200 00000000 0000000c 0
R 208 00000000 00000064 0
# transpose 0 into 3, shape becomes 3x2
W 000 000000c3 00000000 0
P 004 00000000 00000002 0
R 01c 00000000 00000023 0
R 2a8 00000000 ffffffec 0
R 298 00000000 fffffffd 0
# add on mismatched shapes, dst 1 unchanged
W 000 0000000d 00000000 0
P 004 00000000 00000006 0
R 180 00000000 00000064 0
# dst equal to src_a
W 000 00000080 00000000 0
P 004 00000000 00000006 0
R 100 00000000 00000064 0
# six rows rejected, shape kept
W 010 00000036 00000000 2
R 010 00000000 00000032 0
# 5x5 scale of slot 1 into 2, second command lands while busy
W 014 00000055 00000000 0
W 000 00000092 00000000 0
W 000 00000006 00000000 2
P 004 00000000 00000002 0
R 218 00000000 ffffffe7 0
R 200 00000000 0000000c 0
R 018 00000000 00000055 0

// ==== files.f ====
design/mat_pkg.sv
design/axil_pkg.sv
design/axil_regs.sv
design/op_sequencer.sv
design/elem_counter.sv
design/matrix_store.sv
design/elem_alu.sv
design/matrix_top.sv
bench/axil_checker.sv
bench/tb_top.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module tb_top -f files.f
./obj_dir/Vtb_top > sim.log
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi

// ==== bench/tb_top.sv ====
// testbench top, reads host accesses from the stimulus file and drives them into the DUT over AXI4-Lite
module tb_top
    import axil_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // handshake and poll bounds
    localparam int    hs_limit   = 32;
    localparam int    poll_limit = 200;
    localparam string stim_path  = "bench/mat_stim.txt";

    logic       clk;
    logic       rst_n;
    axil_req_t  axil_req;
    axil_rsp_t  axil_rsp;
    axil_data_t exp_data;
    logic [1:0] exp_resp;
    logic       check_en;
    int         error_count;
    int         beat_count;
    int         timeouts;
    int         accesses;
    logic       abort;
    axil_data_t last_rdata;

    matrix_top dut (
        .clk(clk),
        .rst_n(rst_n),
        .axil_req(axil_req),
        .axil_rsp(axil_rsp)
    );

    axil_checker u_checker (
        .clk(clk),
        .rst_n(rst_n),
        .axil_req(axil_req),
        .axil_rsp(axil_rsp),
        .exp_data(exp_data),
        .exp_resp(exp_resp),
        .check_en(check_en),
        .error_count(error_count),
        .beat_count(beat_count)
    );

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ====================
    // helpers
    // ====================

    // back-pressure on bready and rready, 0 to 3 cycles
    function automatic int stall_cycles();
        return int'($urandom % 4);
    endfunction

    task automatic count_timeout(input string what, input axil_addr_t addr);
        $display("timeout: no %s within %0d cycles, address %h", what, hs_limit, addr);
        timeouts++;
        abort = 1'b1;
    endtask

    task automatic write_access(input axil_addr_t addr, input axil_data_t data);
        int   n;
        logic ok;
        n = 0;
        @(posedge clk);
        axil_req.awaddr  <= addr;
        axil_req.awvalid <= 1'b1;
        axil_req.wdata   <= data;
        axil_req.wvalid  <= 1'b1;
        // ready sampled mid-cycle, handshake lands on the next rising edge
        @(negedge clk);
        // awready and wready must rise in the same cycle
        while (!axil_rsp.awready && !axil_rsp.wready && n < hs_limit) begin
            @(negedge clk);
            n++;
        end
        ok = axil_rsp.awready && axil_rsp.wready;
        @(posedge clk);
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        if (!ok) begin
            count_timeout("write address and data handshake", addr);
            return;
        end
        repeat (stall_cycles()) @(posedge clk);
        axil_req.bready <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!axil_rsp.bvalid && n < hs_limit) begin
            @(negedge clk);
            n++;
        end
        ok = axil_rsp.bvalid;
        @(posedge clk);
        axil_req.bready <= 1'b0;
        if (!ok) begin
            count_timeout("write response", addr);
            return;
        end
        accesses++;
    endtask

    task automatic read_access(input axil_addr_t addr);
        int   n;
        logic ok;
        n = 0;
        @(posedge clk);
        axil_req.araddr  <= addr;
        axil_req.arvalid <= 1'b1;
        @(negedge clk);
        while (!axil_rsp.arready && n < hs_limit) begin
            @(negedge clk);
            n++;
        end
        ok = axil_rsp.arready;
        @(posedge clk);
        axil_req.arvalid <= 1'b0;
        if (!ok) begin
            count_timeout("read address handshake", addr);
            return;
        end
        repeat (stall_cycles()) @(posedge clk);
        axil_req.rready <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!axil_rsp.rvalid && n < hs_limit) begin
            @(negedge clk);
            n++;
        end
        ok         = axil_rsp.rvalid;
        last_rdata = axil_rsp.rdata;
        @(posedge clk);
        axil_req.rready <= 1'b0;
        if (!ok) begin
            count_timeout("read data beat", addr);
            return;
        end
        accesses++;
    endtask

    // status reads unchecked until done, bit 1, is seen
    task automatic wait_for_done(input axil_addr_t addr);
        int n;
        n          = 0;
        last_rdata = '0;
        check_en  <= 1'b0;
        while (!last_rdata[1] && !abort && n < poll_limit) begin
            read_access(addr);
            n++;
        end
        if (!abort && !last_rdata[1]) begin
            $display("timeout: done bit still clear after %0d status reads", poll_limit);
            timeouts++;
            abort = 1'b1;
        end
        check_en <= 1'b1;
    endtask

    // ====================
    // stimulus
    // ====================
    initial begin
        int         fd;
        int         code;
        string      line;
        byte        kind;
        axil_addr_t addr;
        axil_data_t wdata;
        axil_data_t edata;
        logic [1:0] eresp;
        void'($urandom(32'hbacb3188));
        axil_req   = '0;
        rst_n      = 1'b0;
        check_en   = 1'b1;
        exp_data   = '0;
        exp_resp   = '0;
        timeouts   = 0;
        accesses   = 0;
        abort      = 1'b0;
        last_rdata = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        fd = $fopen(stim_path, "r");
        if (fd == 0) begin
            $display("could not open stimulus file %s", stim_path);
            abort = 1'b1;
        end
        while (!abort && fd != 0 && !$feof(fd)) begin
            code = $fgets(line, fd);
            // blank lines and # comments skipped
            if (code > 0 && line.len() > 2 && line.getc(0) != "#") begin
                kind = line.getc(0);
                code = $sscanf(line.substr(2, line.len() - 1), "%h %h %h %h",
                               addr, wdata, edata, eresp);
                if (code != 4) begin
                    $display("malformed stimulus line: %s", line);
                    abort = 1'b1;
                end else begin
                    exp_data <= edata;
                    exp_resp <= eresp;
                    case (kind)
                        "W": write_access(addr, wdata);
                        "R": read_access(addr);
                        "P": begin
                            wait_for_done(addr);
                            // one checked read once done is up
                            if (!abort) begin
                                read_access(addr);
                            end
                        end
                        default: begin
                            $display("unknown access kind %c in stimulus file", kind);
                            abort = 1'b1;
                        end
                    endcase
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        repeat (4) @(posedge clk);
        $display("checked %0d beats in %0d accesses, %0d errors, %0d timeouts",
                 beat_count, accesses, error_count, timeouts);
        if (error_count == 0 && timeouts == 0 && !abort && beat_count > 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== bench/axil_checker.sv ====
// response checker, compares every AXI4-Lite B and R beat against the expected values from the testbench
module axil_checker
    import axil_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  axil_req_t  axil_req,
    input  axil_rsp_t  axil_rsp,
    input  axil_data_t exp_data,
    input  logic [1:0] exp_resp,
    input  logic       check_en,
    output int         error_count,
    output int         beat_count
);

    timeunit 1ns;
    timeprecision 1ps;

    int errors = 0;
    int beats  = 0;

    assign error_count = errors;
    assign beat_count  = beats;

    // ====================
    // beat compare
    // ====================

    // sampled mid-cycle, each beat completes on the following rising edge
    always @(negedge clk) begin
        if (rst_n && check_en) begin
            // write response
            if (axil_rsp.bvalid && axil_req.bready) begin
                beats++;
                if (axil_rsp.bresp !== exp_resp) begin
                    $display("Error: bresp expected %h, got %h", exp_resp, axil_rsp.bresp);
                    errors++;
                end
            end
            // read data and response
            if (axil_rsp.rvalid && axil_req.rready) begin
                beats++;
                if (axil_rsp.rresp !== exp_resp) begin
                    $display("Error: rresp expected %h, got %h", exp_resp, axil_rsp.rresp);
                    errors++;
                end
                if (axil_rsp.rdata !== exp_data) begin
                    $display("Error: rdata expected %h, got %h", exp_data, axil_rsp.rdata);
                    errors++;
                end
            end
        end
    end

endmodule

// ==== design/matrix_top.sv ====
// matrix calculator top level, host drives it over AXI4-Lite; wires slave, FSM, counter, store, ALU
module matrix_top
    import mat_pkg::*;
    import axil_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  axil_req_t axil_req,
    output axil_rsp_t axil_rsp
);

    localparam int NUM_SLOTS = 4;
    localparam int MAX_DIM   = 5;

    // ====================
    // control
    // ====================
    logic    cmd_valid;
    op_cmd_t cmd;
    op_cmd_t run_cmd;
    elem_t   scalar;
    logic    busy;
    logic    done;
    logic    error;
    logic    count_start;

    // ====================
    // store ports
    // ====================
    logic   host_we;
    slot_t  host_slot;
    idx_t   host_idx;
    elem_t  host_wdata;
    elem_t  host_rdata;
    logic   shape_we;
    shape_t shape_wdata;
    shape_t host_shape;
    shape_t shape_a;
    shape_t shape_b;
    shape_t res_shape;
    logic   res_shape_we;

    // ====================
    // sweep and datapath
    // ====================
    dim_t  row;
    dim_t  col;
    logic  step_valid;
    logic  last;
    slot_t rd_slot_a;
    idx_t  rd_idx_a;
    slot_t rd_slot_b;
    idx_t  rd_idx_b;
    elem_t rd_data_a;
    elem_t rd_data_b;
    logic  res_we;
    slot_t res_slot;
    idx_t  res_idx;
    elem_t res_data;

    axil_regs #(
        .NUM_SLOTS(NUM_SLOTS),
        .MAX_DIM(MAX_DIM)
    ) u_axil_regs (
        .clk(clk),
        .rst_n(rst_n),
        .axil_req(axil_req),
        .axil_rsp(axil_rsp),
        .cmd_valid(cmd_valid),
        .cmd(cmd),
        .scalar(scalar),
        .busy(busy),
        .done(done),
        .error(error),
        .host_we(host_we),
        .host_slot(host_slot),
        .host_idx(host_idx),
        .host_wdata(host_wdata),
        .host_rdata(host_rdata),
        .shape_we(shape_we),
        .shape_wdata(shape_wdata),
        .host_shape(host_shape)
    );

    op_sequencer #(
        .NUM_SLOTS(NUM_SLOTS)
    ) u_op_sequencer (
        .clk(clk),
        .rst_n(rst_n),
        .cmd_valid(cmd_valid),
        .cmd(cmd),
        .shape_a(shape_a),
        .shape_b(shape_b),
        .last(last),
        .count_start(count_start),
        .res_shape(res_shape),
        .res_shape_we(res_shape_we),
        .busy(busy),
        .done(done),
        .error(error),
        .run_cmd(run_cmd)
    );

    elem_counter #(
        .MAX_DIM(MAX_DIM)
    ) u_elem_counter (
        .clk(clk),
        .rst_n(rst_n),
        .start(count_start),
        .shape(res_shape),
        .row(row),
        .col(col),
        .step_valid(step_valid),
        .last(last)
    );

    // operand shapes follow the running command
    matrix_store #(
        .NUM_SLOTS(NUM_SLOTS),
        .MAX_DIM(MAX_DIM)
    ) u_matrix_store (
        .clk(clk),
        .rst_n(rst_n),
        .host_we(host_we),
        .host_slot(host_slot),
        .host_idx(host_idx),
        .host_wdata(host_wdata),
        .host_rdata(host_rdata),
        .shape_we(shape_we),
        .shape_wdata(shape_wdata),
        .host_shape(host_shape),
        .rd_slot_a(rd_slot_a),
        .rd_idx_a(rd_idx_a),
        .rd_slot_b(rd_slot_b),
        .rd_idx_b(rd_idx_b),
        .rd_data_a(rd_data_a),
        .rd_data_b(rd_data_b),
        .shape_sel_a(run_cmd.src_a),
        .shape_sel_b(run_cmd.src_b),
        .shape_a(shape_a),
        .shape_b(shape_b),
        .res_we(res_we),
        .res_slot(res_slot),
        .res_idx(res_idx),
        .res_data(res_data),
        .res_shape_we(res_shape_we),
        .res_shape(res_shape)
    );

    elem_alu u_elem_alu (
        .run_cmd(run_cmd),
        .scalar(scalar),
        .row(row),
        .col(col),
        .step_valid(step_valid),
        .rd_slot_a(rd_slot_a),
        .rd_idx_a(rd_idx_a),
        .rd_slot_b(rd_slot_b),
        .rd_idx_b(rd_idx_b),
        .rd_data_a(rd_data_a),
        .rd_data_b(rd_data_b),
        .res_we(res_we),
        .res_slot(res_slot),
        .res_idx(res_idx),
        .res_data(res_data)
    );

endmodule

// ==== design/elem_alu.sv ====
// per-step element ALU, forms source and destination indices and the wrapped result value
module elem_alu
    import mat_pkg::*;
(
    input  op_cmd_t run_cmd,
    input  elem_t   scalar,
    input  dim_t    row,
    input  dim_t    col,
    input  logic    step_valid,
    output slot_t   rd_slot_a,
    output idx_t    rd_idx_a,
    output slot_t   rd_slot_b,
    output idx_t    rd_idx_b,
    input  elem_t   rd_data_a,
    input  elem_t   rd_data_b,
    output logic    res_we,
    output slot_t   res_slot,
    output idx_t    res_idx,
    output elem_t   res_data
);

    logic signed [15:0] product;

    // ====================
    // addressing
    // ====================
    assign rd_slot_a = run_cmd.src_a;
    assign rd_slot_b = run_cmd.src_b;
    // transpose reads a(col,row)
    assign rd_idx_a  = (run_cmd.op == op_transpose) ? flat_idx(col, row) : flat_idx(row, col);
    assign rd_idx_b  = flat_idx(row, col);

    assign res_slot = run_cmd.dst;
    assign res_idx  = flat_idx(row, col);
    assign res_we   = step_valid;

    // full product, low byte kept
    assign product = rd_data_a * scalar;

    // results wrap to 8 bits
    always_comb begin
        case (run_cmd.op)
            op_add:   res_data = rd_data_a + rd_data_b;
            op_sub:   res_data = rd_data_a - rd_data_b;
            op_scale: res_data = product[7:0];
            default:  res_data = rd_data_a;
        endcase
    end

endmodule

// ==== design/matrix_store.sv ====
// matrix slot memory with per-slot shapes, two operand read ports, a host port and a result port
module matrix_store
    import mat_pkg::*;
#(
    parameter int NUM_SLOTS = 4,
    parameter int MAX_DIM   = 5
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   host_we,
    input  slot_t  host_slot,
    input  idx_t   host_idx,
    input  elem_t  host_wdata,
    output elem_t  host_rdata,
    input  logic   shape_we,
    input  shape_t shape_wdata,
    output shape_t host_shape,
    input  slot_t  rd_slot_a,
    input  idx_t   rd_idx_a,
    input  slot_t  rd_slot_b,
    input  idx_t   rd_idx_b,
    output elem_t  rd_data_a,
    output elem_t  rd_data_b,
    input  slot_t  shape_sel_a,
    input  slot_t  shape_sel_b,
    output shape_t shape_a,
    output shape_t shape_b,
    input  logic   res_we,
    input  slot_t  res_slot,
    input  idx_t   res_idx,
    input  elem_t  res_data,
    input  logic   res_shape_we,
    input  shape_t res_shape
);

    elem_t  mem    [NUM_SLOTS][MAX_DIM][MAX_DIM];
    shape_t shapes [NUM_SLOTS];

    // out-of-range reads give zero
    function automatic elem_t elem_read(slot_t slot, idx_t idx);
        if (int'(slot) < NUM_SLOTS && int'(idx_row(idx)) < MAX_DIM &&
            int'(idx_col(idx)) < MAX_DIM) begin
            return mem[slot][idx_row(idx)][idx_col(idx)];
        end
        return '0;
    endfunction

    function automatic shape_t shape_read(slot_t slot);
        return (int'(slot) < NUM_SLOTS) ? shapes[slot] : '0;
    endfunction

    // ====================
    // combinational reads
    // ====================
    always_comb begin
        host_rdata = elem_read(host_slot, host_idx);
        rd_data_a  = elem_read(rd_slot_a, rd_idx_a);
        rd_data_b  = elem_read(rd_slot_b, rd_idx_b);
        host_shape = shape_read(host_slot);
        shape_a    = shape_read(shape_sel_a);
        shape_b    = shape_read(shape_sel_b);
    end

    // host and result ports never write in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // unwritten slots read as zero with a zero shape
            for (int s = 0; s < NUM_SLOTS; s++) begin
                shapes[s] <= '0;
                for (int r = 0; r < MAX_DIM; r++) begin
                    for (int c = 0; c < MAX_DIM; c++) begin
                        mem[s][r][c] <= '0;
                    end
                end
            end
        end else begin
            if (host_we) begin
                mem[host_slot][idx_row(host_idx)][idx_col(host_idx)] <= host_wdata;
            end
            if (res_we) begin
                mem[res_slot][idx_row(res_idx)][idx_col(res_idx)] <= res_data;
            end
            if (shape_we) begin
                shapes[host_slot] <= shape_wdata;
            end
            if (res_shape_we) begin
                shapes[res_slot] <= res_shape;
            end
        end
    end

endmodule

// ==== design/elem_counter.sv ====
// row-major sweep counter, one step per cycle over the latched result shape
module elem_counter
    import mat_pkg::*;
#(
    parameter int MAX_DIM = 5
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   start,
    input  shape_t shape,
    output dim_t   row,
    output dim_t   col,
    output logic   step_valid,
    output logic   last
);

    shape_t span;
    dim_t   rows_lim;
    dim_t   cols_lim;

    // never sweep past the array bounds
    assign rows_lim = (int'(shape.rows) > MAX_DIM) ? dim_t'(MAX_DIM) : shape.rows;
    assign cols_lim = (int'(shape.cols) > MAX_DIM) ? dim_t'(MAX_DIM) : shape.cols;

    assign last = step_valid && row == span.rows - dim_t'(1) && col == span.cols - dim_t'(1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            span       <= '0;
            row        <= '0;
            col        <= '0;
            step_valid <= 1'b0;
        end else if (start) begin
            // first step on the next cycle
            span       <= {rows_lim, cols_lim};
            row        <= '0;
            col        <= '0;
            step_valid <= 1'b1;
        end else if (step_valid) begin
            if (last) begin
                step_valid <= 1'b0;
            end else if (col == span.cols - dim_t'(1)) begin
                // wrap to next row
                col <= '0;
                row <= row + dim_t'(1);
            end else begin
                col <= col + dim_t'(1);
            end
        end
    end

endmodule

// ==== design/op_sequencer.sv ====
// command FSM, checks each command, starts the element sweep and keeps the sticky status bits
module op_sequencer
    import mat_pkg::*;
#(
    parameter int NUM_SLOTS = 4
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    cmd_valid,
    input  op_cmd_t cmd,
    input  shape_t  shape_a,
    input  shape_t  shape_b,
    input  logic    last,
    output logic    count_start,
    output shape_t  res_shape,
    output logic    res_shape_we,
    output logic    busy,
    output logic    done,
    output logic    error,
    output op_cmd_t run_cmd
);

    seq_state_e state;
    logic       two_src;
    logic       slots_ok;
    logic       a_ok;
    logic       b_ok;
    logic       checks_ok;

    // ====================
    // command checks
    // ====================
    assign two_src  = (run_cmd.op == op_add) || (run_cmd.op == op_sub);
    // bad destination or slot beyond NUM_SLOTS
    assign slots_ok = int'(run_cmd.src_a) < NUM_SLOTS && int'(run_cmd.dst) < NUM_SLOTS &&
                      run_cmd.dst != run_cmd.src_a;
    // empty slot has zero rows
    assign a_ok     = shape_a.rows != '0;
    assign b_ok     = int'(run_cmd.src_b) < NUM_SLOTS && run_cmd.dst != run_cmd.src_b &&
                      shape_b == shape_a;
    assign checks_ok = slots_ok && a_ok && (!two_src || b_ok);

    // transpose swaps the fields
    assign res_shape = (run_cmd.op == op_transpose) ? {shape_a.cols, shape_a.rows} : shape_a;

    assign count_start  = (state == st_check) && checks_ok;
    // shape lands with the final element
    assign res_shape_we = (state == st_run) && last;
    assign busy         = (state != st_idle);

    // command held for the whole run
    always_ff @(posedge clk) begin
        if (state == st_idle && cmd_valid) begin
            run_cmd <= cmd;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            done  <= 1'b0;
            error <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    // sticky bits clear on the next accepted command
                    if (cmd_valid) begin
                        done  <= 1'b0;
                        error <= 1'b0;
                        state <= st_check;
                    end
                end
                st_check: begin
                    if (checks_ok) begin
                        state <= st_run;
                    end else begin
                        error <= 1'b1;
                        done  <= 1'b1;
                        state <= st_done;
                    end
                end
                st_run: begin
                    if (last) begin
                        done  <= 1'b1;
                        state <= st_done;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

// ==== design/axil_regs.sv ====
// AXI4-Lite register slave, decodes host accesses into commands, status, scalar, shapes and elements
module axil_regs
    import mat_pkg::*;
    import axil_pkg::*;
#(
    parameter int NUM_SLOTS = 4,
    parameter int MAX_DIM   = 5
) (
    input  logic      clk,
    input  logic      rst_n,
    input  axil_req_t axil_req,
    output axil_rsp_t axil_rsp,
    output logic      cmd_valid,
    output op_cmd_t   cmd,
    output elem_t     scalar,
    input  logic      busy,
    input  logic      done,
    input  logic      error,
    output logic      host_we,
    output slot_t     host_slot,
    output idx_t      host_idx,
    output elem_t     host_wdata,
    input  elem_t     host_rdata,
    output logic      shape_we,
    output shape_t    shape_wdata,
    input  shape_t    host_shape
);

    // decoded target of one address
    typedef struct packed {
        logic  is_cmd;
        logic  is_status;
        logic  is_scalar;
        logic  is_shape;
        logic  is_elem;
        slot_t slot;
        idx_t  idx;
    } addr_dec_t;

    // word-aligned addresses only, anything else maps to nothing
    function automatic addr_dec_t decode(axil_addr_t addr);
        addr_dec_t  dec;
        axil_addr_t offs;
        dec = '0;
        if (addr[1:0] == 2'b00) begin
            dec.is_cmd    = (addr == reg_cmd);
            dec.is_status = (addr == reg_status);
            dec.is_scalar = (addr == reg_scalar);
            // shape words
            offs = addr - reg_shape_base;
            if (addr >= reg_shape_base && int'(offs) < 4 * NUM_SLOTS) begin
                dec.is_shape = 1'b1;
                dec.slot     = slot_t'(offs[11:2]);
            end
            // element window, slot in bits 8:7 and idx in bits 6:2
            offs = addr - elem_base;
            if (addr >= elem_base && int'(offs) < NUM_SLOTS * int'(elem_slot_span)) begin
                dec.slot    = offs[8:7];
                dec.idx     = offs[6:2];
                // idx past the last row or col of MAX_DIM is a hole
                dec.is_elem = int'(idx_row(offs[6:2])) < MAX_DIM &&
                              int'(idx_col(offs[6:2])) < MAX_DIM;
            end
        end
        return dec;
    endfunction

    addr_dec_t  wr_dec;
    addr_dec_t  rd_dec;
    logic       ar_fire;
    logic       wr_fire;
    logic       wr_mapped;
    logic       wr_err;
    shape_t     wr_shape;
    logic       shape_legal;
    logic       bvalid_q;
    axil_resp_e bresp_q;
    logic       rvalid_q;
    axil_resp_e rresp_q;
    axil_data_t rdata_q;
    axil_data_t rd_value;
    logic       rd_err;
    elem_t      scalar_q;

    assign wr_dec = decode(axil_req.awaddr);
    assign rd_dec = decode(axil_req.araddr);

    // ====================
    // handshakes
    // ====================

    // one read outstanding
    assign ar_fire = axil_req.arvalid & ~rvalid_q;
    // write waits out a read handshake, the two share the store host port
    assign wr_fire = axil_req.awvalid & axil_req.wvalid & ~bvalid_q & ~ar_fire;

    // rows in bits 2:0, cols in bits 6:4
    assign wr_shape    = {axil_req.wdata[2:0], axil_req.wdata[6:4]};
    assign shape_legal = wr_shape.rows != '0 && int'(wr_shape.rows) <= MAX_DIM &&
                         wr_shape.cols != '0 && int'(wr_shape.cols) <= MAX_DIM;

    // status is read only and so not writable
    assign wr_mapped = wr_dec.is_cmd | wr_dec.is_scalar | wr_dec.is_shape | wr_dec.is_elem;
    // scalar stays writable while busy, everything else is locked
    assign wr_err    = !wr_mapped || (busy && !wr_dec.is_scalar) ||
                       (wr_dec.is_shape && !shape_legal);

    // side effects of an accepted write
    assign cmd_valid   = wr_fire & wr_dec.is_cmd & ~wr_err;
    assign cmd         = op_cmd_t'(axil_req.wdata[7:0]);
    assign host_we     = wr_fire & wr_dec.is_elem & ~wr_err;
    assign host_wdata  = elem_t'(axil_req.wdata[7:0]);
    assign shape_we    = wr_fire & wr_dec.is_shape & ~wr_err;
    assign shape_wdata = wr_shape;

    // host port address follows whichever channel fires
    assign host_slot = ar_fire ? rd_dec.slot : wr_dec.slot;
    assign host_idx  = ar_fire ? rd_dec.idx : wr_dec.idx;

    // read mux, values sign-extended
    always_comb begin
        rd_value = '0;
        rd_err   = 1'b0;
        if (rd_dec.is_status) begin
            rd_value = {29'd0, error, done, busy};
        end else if (rd_dec.is_scalar) begin
            rd_value = axil_data_t'(scalar_q);
        end else if (rd_dec.is_shape) begin
            rd_value = {25'd0, host_shape.cols, 1'b0, host_shape.rows};
        end else if (rd_dec.is_elem) begin
            rd_value = axil_data_t'(host_rdata);
        end else begin
            // command register is write only
            rd_err = 1'b1;
        end
    end

    // ====================
    // response channels and scalar
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid_q <= 1'b0;
            bresp_q  <= resp_okay;
            rvalid_q <= 1'b0;
            rresp_q  <= resp_okay;
            scalar_q <= 8'sd3;
        end else begin
            if (wr_fire) begin
                bvalid_q <= 1'b1;
                bresp_q  <= wr_err ? resp_slverr : resp_okay;
            end else if (axil_req.bready) begin
                bvalid_q <= 1'b0;
            end
            if (ar_fire) begin
                rvalid_q <= 1'b1;
                rresp_q  <= rd_err ? resp_slverr : resp_okay;
            end else if (axil_req.rready) begin
                rvalid_q <= 1'b0;
            end
            if (wr_fire && wr_dec.is_scalar) begin
                scalar_q <= elem_t'(axil_req.wdata[7:0]);
            end
        end
    end

    // read data held until rready
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rdata_q <= rd_value;
        end
    end

    assign scalar = scalar_q;

    assign axil_rsp.awready = wr_fire;
    assign axil_rsp.wready  = wr_fire;
    assign axil_rsp.bresp   = bresp_q;
    assign axil_rsp.bvalid  = bvalid_q;
    assign axil_rsp.arready = ~rvalid_q;
    assign axil_rsp.rdata   = rdata_q;
    assign axil_rsp.rresp   = rresp_q;
    assign axil_rsp.rvalid  = rvalid_q;

endmodule

// ==== design/axil_pkg.sv ====
// AXI4-Lite channel structs, response codes and register map, imported by the host-side modules
package axil_pkg;

    // byte address and data word
    typedef logic [11:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;

    // only OKAY and SLVERR are ever returned
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axil_resp_e;

    // master to slave
    typedef struct packed {
        axil_addr_t awaddr;
        logic       awvalid;
        axil_data_t wdata;
        logic       wvalid;
        logic       bready;
        axil_addr_t araddr;
        logic       arvalid;
        logic       rready;
    } axil_req_t;

    // slave to master
    typedef struct packed {
        logic       awready;
        logic       wready;
        axil_resp_e bresp;
        logic       bvalid;
        logic       arready;
        axil_data_t rdata;
        axil_resp_e rresp;
        logic       rvalid;
    } axil_rsp_t;

    // ====================
    // register map
    // ====================
    localparam axil_addr_t reg_cmd        = 12'h000;
    localparam axil_addr_t reg_status     = 12'h004;
    localparam axil_addr_t reg_scalar     = 12'h008;
    // one shape word per slot, stride 4
    localparam axil_addr_t reg_shape_base = 12'h010;
    // element window, one word per element at idx * 4
    localparam axil_addr_t elem_base      = 12'h100;
    localparam axil_addr_t elem_slot_span = 12'h080;

endpackage

// ==== design/mat_pkg.sv ====
// matrix element, shape, slot and operation types, imported by the datapath and control modules
package mat_pkg;

    // ====================
    // element and index types
    // ====================

    // one signed matrix element
    typedef logic signed [7:0] elem_t;

    // row or column count, legal range 1 to 5
    typedef logic [2:0] dim_t;

    // matrix slot number
    typedef logic [1:0] slot_t;

    // flat element index, row * 5 + col
    typedef logic [4:0] idx_t;

    // row pitch of the flat index, fixed whatever MAX_DIM is
    localparam int row_stride = 5;

    // rows in the upper field, cols in the lower
    typedef struct packed {
        dim_t rows;
        dim_t cols;
    } shape_t;

    // ====================
    // operations
    // ====================

    typedef enum logic [1:0] {
        op_add,
        op_sub,
        op_scale,
        op_transpose
    } op_e;

    // same bit layout as the command register, bits 7:0
    typedef struct packed {
        op_e   op;
        slot_t src_a;
        slot_t src_b;
        slot_t dst;
    } op_cmd_t;

    // sequencer states
    typedef enum logic [1:0] {
        st_idle,
        st_check,
        st_run,
        st_done
    } seq_state_e;

    // row and col to flat index
    function automatic idx_t flat_idx(dim_t row, dim_t col);
        return idx_t'(row * row_stride + col);
    endfunction

    // flat index back to row
    function automatic dim_t idx_row(idx_t idx);
        return dim_t'(idx / row_stride);
    endfunction

    // flat index back to col
    function automatic dim_t idx_col(idx_t idx);
        return dim_t'(idx % row_stride);
    endfunction

endpackage
